/* decompose_top.f */
common/dcmp_pkg.sv
decompose/dcmp_ctrl.sv
decompose/dcmp_lane.sv
decompose/dcmp_w1_pack.sv
design/decompose_top.sv
testbench/tb_decompose_top.sv

/* Bender.yml */
package:
  name: decompose_top

sources:
  - common/dcmp_pkg.sv
  - decompose/dcmp_ctrl.sv
  - decompose/dcmp_lane.sv
  - decompose/dcmp_w1_pack.sv
  - design/decompose_top.sv
  - target: test
    files:
      - testbench/tb_decompose_top.sv

/* testbench/tb_decompose_top.sv */
// Testbench for the coefficient decomposition unit
// Source, hint, r0 and z memory models, a reference decomposition model,
// random and directed runs in sign and verify mode

module tb_decompose_top;
    localparam int ADDR_W      = 10;
    localparam int NUM_WORDS   = 64;
    localparam int MEM_DEPTH   = 1 << ADDR_W;
    localparam int NUM_TESTS   = 4;
    localparam int CYCLE_LIMIT = NUM_TESTS * (NUM_WORDS + 20);
    localparam int Q           = dcmp_pkg::DILITHIUM_Q;
    localparam int G2          = dcmp_pkg::GAMMA2;
    localparam int TG2         = dcmp_pkg::TWO_GAMMA2;
    localparam int LANES       = dcmp_pkg::LANES;
    localparam int SW          = dcmp_pkg::SLOT_W;

    logic                 clk;
    logic                 reset_n;
    logic                 start;
    dcmp_pkg::dcmp_mode_e mode;
    logic [ADDR_W-1:0]    src_base;
    logic [ADDR_W-1:0]    dest_base;
    logic [ADDR_W-1:0]    hint_base;
    logic                 rd_en;
    logic [ADDR_W-1:0]    rd_addr;
    dcmp_pkg::word_t      rd_data;
    logic                 hint_rd_en;
    logic [ADDR_W-1:0]    hint_rd_addr;
    dcmp_pkg::word_t      hint_data;
    logic                 wr_en;
    logic [ADDR_W-1:0]    wr_addr;
    dcmp_pkg::word_t      wr_data;
    logic                 z_wr_en;
    logic [ADDR_W-1:0]    z_addr;
    logic [LANES-1:0]     z;
    logic [63:0]          w1;
    logic                 w1_valid;
    logic                 done;

    // Memory models
    dcmp_pkg::word_t      src_mem [MEM_DEPTH];
    dcmp_pkg::word_t      hint_mem [MEM_DEPTH];
    dcmp_pkg::word_t      dest_mem [MEM_DEPTH];
    logic [LANES-1:0]     z_mem [MEM_DEPTH];

    // Expected images of the current run
    dcmp_pkg::word_t      exp_dest [NUM_WORDS];
    logic [LANES-1:0]     exp_z [NUM_WORDS];
    logic [63:0]          exp_w1 [$];

    integer               seed;
    int                   cycles = 0;
    int                   errors;
    int                   test_errors;
    int                   failed_tests;
    int                   rd_cnt;
    int                   w1_cnt;
    int                   done_cnt;
    logic                 cur_verify;
    int                   cur_src;
    int                   cur_dest;
    int                   cur_hint;
    // Read strobe and offset trail, index 2 is three cycles old
    logic [2:0]           rd_hist;
    int                   off_hist [3];

    decompose_top #(
        .ADDR_W    (ADDR_W),
        .NUM_WORDS (NUM_WORDS)
    ) u_decompose_top (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start),
        .mode_i         (mode),
        .src_base_i     (src_base),
        .dest_base_i    (dest_base),
        .hint_base_i    (hint_base),
        .rd_en_o        (rd_en),
        .rd_addr_o      (rd_addr),
        .rd_data_i      (rd_data),
        .hint_rd_en_o   (hint_rd_en),
        .hint_rd_addr_o (hint_rd_addr),
        .hint_rd_data_i (hint_data),
        .wr_en_o        (wr_en),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data),
        .z_wr_en_o      (z_wr_en),
        .z_addr_o       (z_addr),
        .z_o            (z),
        .w1_o           (w1),
        .w1_valid_o     (w1_valid),
        .done_o         (done)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [95:0] exp,
                               input logic [95:0] act);
        assert (act === exp) else begin
            $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        assert (ok) else begin
            $display("Error at t=%0t: %s", $time, what);
            test_errors++;
        end
    endtask

    // Centred split of r by 2*GAMMA2, r1 forced to 0 where r - r0 hits q-1
    task automatic split_coef(input int r, output int r0, output int r1);
        int rp;
        rp = r % TG2;
        r0 = (rp > G2) ? rp - TG2 : rp;
        if (r - r0 == Q - 1) begin
            r1 = 0;
            r0 = r0 - 1;
        end else begin
            r1 = (r - r0) / TG2;
        end
    endtask

    // Hint steps r1 toward the side of r0, wrapping in 16
    function automatic int apply_hint(input int r0, input int r1, input logic h);
        if (!h) begin
            return r1;
        end
        return (r0 > 0) ? (r1 + 1) % 16 : (r1 + 15) % 16;
    endfunction

    task automatic build_expected(input logic verify, input int src, input int hnt);
        dcmp_pkg::word_t w;
        dcmp_pkg::word_t hw;
        logic [15:0]     grp;
        logic [63:0]     pack;
        int              r;
        int              r0;
        int              r1;
        exp_w1.delete();
        for (int off = 0; off < NUM_WORDS; off++) begin
            w  = src_mem[src + off];
            hw = hint_mem[hnt + off];
            for (int ln = 0; ln < LANES; ln++) begin
                r = int'(w[ln*SW +: dcmp_pkg::COEF_W]);
                split_coef(r, r0, r1);
                exp_dest[off][ln*SW +: SW] = SW'((r0 < 0) ? r0 + Q : r0);
                exp_z[off][ln] = (r1 != 0);
                if (verify) begin
                    r1 = apply_hint(r0, r1, hw[ln*SW]);
                end
                grp[ln*4 +: 4] = 4'(r1);
            end
            // First group of a word in the low bits
            pack[(off % 4)*16 +: 16] = grp;
            if (off % 4 == 3) begin
                exp_w1.push_back(pack);
            end
        end
    endtask

    // Random coefficients below q everywhere, random hint words
    task automatic fill_memories();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            for (int ln = 0; ln < LANES; ln++) begin
                src_mem[a][ln*SW +: SW] = SW'({$random(seed)} % Q);
            end
            hint_mem[a] = {$random(seed), $random(seed), $random(seed)};
        end
    endtask

    // Corner and rounding boundary values, repeated over the whole run
    task automatic load_directed(input int base);
        int vals[$];
        int v;
        vals.push_back(0);
        vals.push_back(Q - 1);
        vals.push_back(Q - 1 - G2);
        vals.push_back(Q - G2);
        for (int k = 0; k <= 16; k++) begin
            v = k * TG2 - G2;
            if (v >= 0) begin
                vals.push_back(v);
            end
            if (v + 1 >= 0) begin
                vals.push_back(v + 1);
            end
            if (v + TG2 < Q) begin
                vals.push_back(v + TG2);
            end
        end
        for (int i = 0; i < NUM_WORDS * LANES; i++) begin
            src_mem[base + i / LANES][(i % LANES)*SW +: SW] = SW'(vals[i % vals.size()]);
        end
    endtask

    // Source and hint reads answer one cycle after the strobe
    always @(posedge clk) begin
        if (rd_en) begin
            rd_data <= src_mem[rd_addr];
        end
        if (hint_rd_en) begin
            hint_data <= hint_mem[hint_rd_addr];
        end
    end

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_hist <= '0;
        end else begin
            rd_hist     <= {rd_hist[1:0], rd_en};
            off_hist[0] <= int'(rd_addr) - cur_src;
            off_hist[1] <= off_hist[0];
            off_hist[2] <= off_hist[1];
        end
    end

    // Bus monitor, write capture and w1 compare
    always @(posedge clk) begin
        if (reset_n) begin
            check_cond(hint_rd_en === (rd_en && cur_verify), "hint read strobe off its mode");
            if (rd_en) begin
                check_value("rd_addr_o", (cur_src + rd_cnt) % MEM_DEPTH, rd_addr);
                if (hint_rd_en) begin
                    check_value("hint_rd_addr_o", (cur_hint + rd_cnt) % MEM_DEPTH,
                                hint_rd_addr);
                end
                rd_cnt++;
            end
            // Writes exactly 3 cycles after the read, sign mode only
            check_cond(wr_en === (rd_hist[2] && !cur_verify), "r0 write strobe out of place");
            check_cond(z_wr_en === (rd_hist[2] && !cur_verify), "z write strobe out of place");
            if (wr_en) begin
                check_value("wr_addr_o", (cur_dest + off_hist[2]) % MEM_DEPTH, wr_addr);
                dest_mem[wr_addr] = wr_data;
            end
            if (z_wr_en) begin
                check_value("z_addr_o", off_hist[2], z_addr);
                z_mem[z_addr] = z;
            end
            if (w1_valid) begin
                w1_cnt++;
                if (exp_w1.size() == 0) begin
                    check_cond(1'b0, "more w1 words than the model expects");
                end else begin
                    check_value("w1_o", exp_w1.pop_front(), w1);
                end
            end
            if (done) begin
                done_cnt++;
                check_cond(w1_valid && w1_cnt == NUM_WORDS / 4,
                           "done_o not in the cycle of the last w1 word");
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic run_test(input string name, input dcmp_pkg::dcmp_mode_e m, input int src,
                            input int dst, input int hnt, input logic restart);
        build_expected(m == dcmp_pkg::MODE_VERIFY, src, hnt);
        for (int a = 0; a < MEM_DEPTH; a++) begin
            dest_mem[a] = '1;
            z_mem[a]    = 'x;
        end
        cur_verify  = (m == dcmp_pkg::MODE_VERIFY);
        cur_src     = src;
        cur_dest    = dst;
        cur_hint    = hnt;
        rd_cnt      = 0;
        w1_cnt      = 0;
        done_cnt    = 0;
        test_errors = 0;
        @(negedge clk);
        start     = 1'b1;
        mode      = m;
        src_base  = ADDR_W'(src);
        dest_base = ADDR_W'(dst);
        hint_base = ADDR_W'(hnt);
        @(negedge clk);
        start = 1'b0;
        if (restart) begin
            // Busy unit must drop this one
            repeat (NUM_WORDS / 2) @(negedge clk);
            start     = 1'b1;
            mode      = dcmp_pkg::MODE_VERIFY;
            src_base  = '0;
            dest_base = '0;
            @(negedge clk);
            start = 1'b0;
        end
        while (done_cnt == 0) begin
            @(negedge clk);
        end
        // Room for a stray second done or extra reads
        repeat (4) @(negedge clk);
        check_cond(done_cnt == 1, $sformatf("done_o pulsed %0d times in one run", done_cnt));
        check_cond(rd_cnt == NUM_WORDS, $sformatf("%0d reads issued in one run", rd_cnt));
        check_cond(w1_cnt == NUM_WORDS / 4 && exp_w1.size() == 0,
                   "w1 word count differs from the model");
        if (!cur_verify) begin
            for (int off = 0; off < NUM_WORDS; off++) begin
                check_value("wr_data_o", exp_dest[off], dest_mem[(dst + off) % MEM_DEPTH]);
                check_value("z_o", exp_z[off], z_mem[off]);
            end
        end
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            failed_tests++;
        end
        errors += test_errors;
    endtask

    initial begin
        seed         = 32'h5c62_c9a2;
        errors       = 0;
        test_errors  = 0;
        failed_tests = 0;
        reset_n      = 1'b0;
        start        = 1'b0;
        mode         = dcmp_pkg::MODE_SIGN;
        src_base     = '0;
        dest_base    = '0;
        hint_base    = '0;
        rd_data      = '0;
        hint_data    = '0;
        cur_verify   = 1'b0;
        cur_src      = 0;
        cur_dest     = 0;
        cur_hint     = 0;
        fill_memories();
        load_directed(128);
        repeat (2) @(negedge clk);
        reset_n = 1'b1;

        run_test("sign_random", dcmp_pkg::MODE_SIGN, 0, 256, 512, 1'b0);
        run_test("verify_hint", dcmp_pkg::MODE_VERIFY, 64, 320, 576, 1'b0);
        run_test("corner_directed", dcmp_pkg::MODE_SIGN, 128, 384, 512, 1'b0);
        run_test("start_mid_run", dcmp_pkg::MODE_SIGN, 192, 448, 512, 1'b1);

        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* design/decompose_top.sv */
// Coefficient decomposition unit
// Controller, four decompose lanes and the w1 packer between the memory ports

module decompose_top #(
    parameter int ADDR_W    = 10,
    parameter int NUM_WORDS = 64
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       start_i,
    input  dcmp_pkg::dcmp_mode_e       mode_i,
    input  logic [ADDR_W-1:0]          src_base_i,
    input  logic [ADDR_W-1:0]          dest_base_i,
    input  logic [ADDR_W-1:0]          hint_base_i,
    output logic                       rd_en_o,
    output logic [ADDR_W-1:0]          rd_addr_o,
    input  dcmp_pkg::word_t            rd_data_i,
    output logic                       hint_rd_en_o,
    output logic [ADDR_W-1:0]          hint_rd_addr_o,
    input  dcmp_pkg::word_t            hint_rd_data_i,
    output logic                       wr_en_o,
    output logic [ADDR_W-1:0]          wr_addr_o,
    output dcmp_pkg::word_t            wr_data_o,
    output logic                       z_wr_en_o,
    output logic [ADDR_W-1:0]          z_addr_o,
    output logic [dcmp_pkg::LANES-1:0] z_o,
    output logic [63:0]                w1_o,
    output logic                       w1_valid_o,
    output logic                       done_o
);
    logic                         lane_en;
    logic                         verify;
    logic                         group_valid;
    // Lane i owns nibble i of the group
    logic [4*dcmp_pkg::LANES-1:0] group;

    dcmp_ctrl #(
        .ADDR_W    (ADDR_W),
        .NUM_WORDS (NUM_WORDS)
    ) u_dcmp_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start_i),
        .mode_i         (mode_i),
        .src_base_i     (src_base_i),
        .dest_base_i    (dest_base_i),
        .hint_base_i    (hint_base_i),
        .rd_en_o        (rd_en_o),
        .rd_addr_o      (rd_addr_o),
        .hint_rd_en_o   (hint_rd_en_o),
        .hint_rd_addr_o (hint_rd_addr_o),
        .lane_en_o      (lane_en),
        .wr_en_o        (wr_en_o),
        .wr_addr_o      (wr_addr_o),
        .z_wr_en_o      (z_wr_en_o),
        .z_addr_o       (z_addr_o),
        .group_valid_o  (group_valid),
        .verify_o       (verify),
        .done_o         (done_o)
    );

    for (genvar i = 0; i < dcmp_pkg::LANES; i++) begin : g_lane
        dcmp_pkg::coef_t lane_r0;

        // Coefficient in the low bits of its slot, hint in bit 0
        dcmp_lane u_dcmp_lane (
            .clk      (clk),
            .reset_n  (reset_n),
            .en_i     (lane_en),
            .verify_i (verify),
            .coef_i   (rd_data_i[i*dcmp_pkg::SLOT_W +: dcmp_pkg::COEF_W]),
            .hint_i   (hint_rd_data_i[i*dcmp_pkg::SLOT_W]),
            .r0_o     (lane_r0),
            .r1_o     (group[i*4 +: 4]),
            .nz_o     (z_o[i])
        );

        // Top bit of each slot stays zero
        assign wr_data_o[i*dcmp_pkg::SLOT_W +: dcmp_pkg::SLOT_W] = {1'b0, lane_r0};
    end

    dcmp_w1_pack u_dcmp_w1_pack (
        .clk           (clk),
        .reset_n       (reset_n),
        .group_valid_i (group_valid),
        .group_i       (group),
        .w1_o          (w1_o),
        .w1_valid_o    (w1_valid_o)
    );

endmodule

/* decompose/dcmp_w1_pack.sv */
// w1 packer
// Gathers four 16-bit r1 groups into one 64-bit word for the hash engine

module dcmp_w1_pack (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        group_valid_i,
    input  logic [15:0] group_i,
    output logic [63:0] w1_o,
    output logic        w1_valid_o
);
    // Groups already placed in the current word
    logic [1:0]  grp_cnt;
    // First three groups, oldest in the low bits
    logic [47:0] acc_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grp_cnt    <= 2'd0;
            w1_valid_o <= 1'b0;
        end else begin
            w1_valid_o <= group_valid_i && (grp_cnt == 2'd3);
            if (group_valid_i) begin
                // Wraps to zero after the fourth group
                grp_cnt <= grp_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (group_valid_i) begin
            if (grp_cnt == 2'd3) begin
                // Fourth group completes the word
                w1_o <= {group_i, acc_q};
            end else begin
                acc_q[grp_cnt*16 +: 16] <= group_i;
            end
        end
    end

    // One word needs four groups, so valid never repeats back to back
    a_valid_gap: assert property (@(posedge clk) disable iff (!reset_n)
        w1_valid_o |=> !w1_valid_o);

endmodule

/* decompose/dcmp_lane.sv */
// Decompose lane
// Splits one coefficient into r1 and centred r0 over two register stages,
// with the q-1 corner case, the nonzero flag and use-hint correction

module dcmp_lane (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            en_i,
    input  logic            verify_i,
    input  dcmp_pkg::coef_t coef_i,
    input  logic            hint_i,
    output dcmp_pkg::coef_t r0_o,
    output dcmp_pkg::r1_t   r1_o,
    output logic            nz_o
);
    // Stage 1 combinational
    logic [16:0]        rnd;
    logic [26:0]        quot_mul;
    logic [4:0]         r1_full;
    logic signed [20:0] r0_cent;
    logic               corner;

    // Stage 1 registers
    dcmp_pkg::r1_t      r1_s1;
    logic signed [20:0] r0c_s1;
    logic               corner_s1;
    logic               hint_s1;

    // Stage 2 combinational
    logic signed [20:0] r0_adj;
    logic signed [23:0] r0_wide;
    dcmp_pkg::r1_t      r1_fix;

    always_comb begin
        // Rounded quotient by 2*GAMMA2 through a 2^7 prescale and reciprocal multiply
        rnd      = 17'((24'(coef_i) + 24'd127) >> 7);
        quot_mul = 27'(rnd) * 27'd1025 + 27'(1 << 21);
        r1_full  = quot_mul[26:22];
        // Remainder centred around the chosen multiple
        r0_cent  = 21'($signed({1'b0, coef_i}) - $signed({19'b0, r1_full}) * dcmp_pkg::TWO_GAMMA2);
        // r - r0 reached q-1, high part wraps to 0
        corner   = (r1_full == 5'd16);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r1_s1     <= '0;
            r0c_s1    <= '0;
            corner_s1 <= 1'b0;
            hint_s1   <= 1'b0;
        end else if (en_i) begin
            // Corner value 16 drops to 0 in four bits
            r1_s1     <= r1_full[3:0];
            r0c_s1    <= r0_cent;
            corner_s1 <= corner;
            hint_s1   <= hint_i;
        end
    end

    always_comb begin
        // Corner lowers r0 by one
        r0_adj  = corner_s1 ? r0c_s1 - 21'sd1 : r0c_s1;
        // Back into [0, q)
        r0_wide = r0_adj;
        if (r0_wide < 0) begin
            r0_wide = r0_wide + 24'(dcmp_pkg::DILITHIUM_Q);
        end
        // Use-hint moves r1 toward the side r0 points to, mod 16
        r1_fix = r1_s1;
        if (verify_i && hint_s1) begin
            r1_fix = (r0_adj > 0) ? r1_s1 + 4'd1 : r1_s1 - 4'd1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r0_o <= '0;
            r1_o <= '0;
            nz_o <= 1'b0;
        end else if (en_i) begin
            r0_o <= r0_wide[dcmp_pkg::COEF_W-1:0];
            r1_o <= r1_fix;
            // Flag taken from the uncorrected high part
            nz_o <= (r1_s1 != 4'd0);
        end
    end

    // Centred low part held in stage 1 stays inside (-GAMMA2, GAMMA2]
    a_r0_range: assert property (@(posedge clk) disable iff (!reset_n)
        $past(en_i) && !$isunknown(r0c_s1)
            |-> (r0c_s1 > -dcmp_pkg::GAMMA2) && (r0c_s1 <= dcmp_pkg::GAMMA2));

endmodule

/* decompose/dcmp_ctrl.sv */
// Decompose controller
// Start/busy FSM, source and hint read addressing, three-stage valid pipeline,
// r0 and z write addressing and the done pulse

module dcmp_ctrl #(
    parameter int ADDR_W    = 10,
    parameter int NUM_WORDS = 64
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start_i,
    input  dcmp_pkg::dcmp_mode_e mode_i,
    input  logic [ADDR_W-1:0]    src_base_i,
    input  logic [ADDR_W-1:0]    dest_base_i,
    input  logic [ADDR_W-1:0]    hint_base_i,
    output logic                 rd_en_o,
    output logic [ADDR_W-1:0]    rd_addr_o,
    output logic                 hint_rd_en_o,
    output logic [ADDR_W-1:0]    hint_rd_addr_o,
    output logic                 lane_en_o,
    output logic                 wr_en_o,
    output logic [ADDR_W-1:0]    wr_addr_o,
    output logic                 z_wr_en_o,
    output logic [ADDR_W-1:0]    z_addr_o,
    output logic                 group_valid_o,
    output logic                 verify_o,
    output logic                 done_o
);
    localparam logic [ADDR_W-1:0] LAST_OFF = ADDR_W'(NUM_WORDS - 1);

    dcmp_pkg::ctrl_state_e state;
    dcmp_pkg::dcmp_mode_e  mode_q;
    logic [ADDR_W-1:0]     src_base_q;
    logic [ADDR_W-1:0]     dest_base_q;
    logic [ADDR_W-1:0]     hint_base_q;
    logic [ADDR_W-1:0]     rd_off;
    // Bit 0 data at lanes, bit 1 stage 1 valid, bit 2 stage 2 valid
    logic [2:0]            vld_q;
    logic [ADDR_W-1:0]     off_q [3];
    logic                  start_ok;
    logic                  last_out;

    // Start only taken when idle
    assign start_ok = start_i && (state == dcmp_pkg::IDLE);
    // Final word leaving stage 2
    assign last_out = vld_q[2] && (off_q[2] == LAST_OFF);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= dcmp_pkg::IDLE;
            mode_q  <= dcmp_pkg::MODE_SIGN;
            rd_en_o <= 1'b0;
            rd_off  <= '0;
            vld_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            vld_q  <= {vld_q[1:0], rd_en_o};
            done_o <= last_out;
            case (state)
                dcmp_pkg::IDLE: begin
                    if (start_ok) begin
                        state   <= dcmp_pkg::RUN;
                        mode_q  <= mode_i;
                        rd_en_o <= 1'b1;
                        rd_off  <= '0;
                    end
                end
                dcmp_pkg::RUN: begin
                    // One read per cycle until the last offset
                    if (rd_off == LAST_OFF) begin
                        rd_en_o <= 1'b0;
                        state   <= dcmp_pkg::DRAIN;
                    end else begin
                        rd_off <= rd_off + 1'b1;
                    end
                end
                dcmp_pkg::DRAIN: begin
                    if (last_out) begin
                        state <= dcmp_pkg::IDLE;
                    end
                end
                default: state <= dcmp_pkg::IDLE;
            endcase
        end
    end

    // Bases and offset trail
    always_ff @(posedge clk) begin
        if (start_ok) begin
            src_base_q  <= src_base_i;
            dest_base_q <= dest_base_i;
            hint_base_q <= hint_base_i;
        end
        off_q[0] <= rd_off;
        off_q[1] <= off_q[0];
        off_q[2] <= off_q[1];
    end

    assign verify_o       = (mode_q == dcmp_pkg::MODE_VERIFY);
    assign rd_addr_o      = src_base_q + rd_off;
    assign hint_rd_en_o   = rd_en_o && verify_o;
    assign hint_rd_addr_o = hint_base_q + rd_off;
    // Lane registers move while stage 1 or stage 2 holds data
    assign lane_en_o      = vld_q[0] || vld_q[1];
    assign group_valid_o  = vld_q[2];
    // r0 and z writes only in sign mode
    assign wr_en_o        = vld_q[2] && !verify_o;
    assign wr_addr_o      = dest_base_q + off_q[2];
    assign z_wr_en_o      = vld_q[2] && !verify_o;
    assign z_addr_o       = off_q[2];

    // Each r0 write belongs to a sign-mode read issued three cycles before
    a_wr_timing: assert property (@(posedge clk) disable iff (!reset_n)
        wr_en_o |-> $past(rd_en_o && !hint_rd_en_o, 3));

    // A new read burst only once the previous run has fully drained
    a_start_idle: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(rd_en_o) |-> (vld_q == 3'b000));

endmodule

/* common/dcmp_pkg.sv */
// Decompose unit shared definitions
// Coefficient field widths, modulus constants, payload types and FSM encodings

package dcmp_pkg;

    // Coefficient width and its slot inside a memory word
    localparam int COEF_W = 23;
    localparam int SLOT_W = 24;

    // Coefficients carried by one memory word
    localparam int LANES = 4;

    // Modulus q, fits in COEF_W bits
    localparam int DILITHIUM_Q = 8380417;

    // Centring bound for the low part
    localparam int GAMMA2 = (DILITHIUM_Q - 1) / 32;

    // Step between consecutive r1 values
    localparam int TWO_GAMMA2 = 2 * GAMMA2;

    // One coefficient, also used for r0 mod q
    typedef logic [COEF_W-1:0] coef_t;

    // Four coefficient slots, coefficient in the low bits of each
    typedef logic [LANES*SLOT_W-1:0] word_t;

    // High part, always below 16
    typedef logic [3:0] r1_t;

    typedef enum logic {
        MODE_SIGN,
        MODE_VERIFY
    } dcmp_mode_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } ctrl_state_e;

endpackage
